// File: design/fetch_ctrl_regs.sv
`timescale 1ns/1ps

module fetch_ctrl_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_we,
    input  rv32i_types::cfg_addr_t          cfg_addr,
    input  logic [31:0]                     cfg_wdata,
    output logic [31:0]                     cfg_rdata,    // combinational readback
    input  logic                            pkt_fetched,  // pulse per push
    output logic                            run_en,
    output logic [rv32i_types::xlen-1:0]    boot_pc,
    output logic                            restart       // one cycle after a boot pc write
);

    logic [31:0] fetched_cnt;                             // saturating packet counter
    logic        wr_boot;
    logic        wr_enable;
    logic        wr_fetched;

    assign wr_boot    = cfg_we && (cfg_addr == rv32i_types::cfg_boot_pc);
    assign wr_enable  = cfg_we && (cfg_addr == rv32i_types::cfg_enable);
    assign wr_fetched = cfg_we && (cfg_addr == rv32i_types::cfg_fetched);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            boot_pc     <= '0;
            run_en      <= 1'b0;
            restart     <= 1'b0;
            fetched_cnt <= '0;
        end
        else
        begin
            restart <= wr_boot;                           // fetch reloads from new boot_pc
            if (wr_boot)
            begin
                boot_pc <= cfg_wdata;
            end
            if (wr_enable)
            begin
                run_en <= cfg_wdata[0];
            end
            if (wr_fetched)
            begin
                fetched_cnt <= '0;                        // clear beats a same-cycle push
            end
            else if (pkt_fetched && !(&fetched_cnt))
            begin
                fetched_cnt <= fetched_cnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        case (cfg_addr)
            rv32i_types::cfg_boot_pc: cfg_rdata = boot_pc;
            rv32i_types::cfg_enable:  cfg_rdata = {31'b0, run_en};
            rv32i_types::cfg_fetched: cfg_rdata = fetched_cnt;
            default:                  cfg_rdata = '0; // unmapped address
        endcase
    end

endmodule : fetch_ctrl_regs

// File: design/fetch_queue_top.sv
`timescale 1ns/1ps

module fetch_queue_top #(
    parameter int queue_depth = 8                          // power of two, at least 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_we,
    input  rv32i_types::cfg_addr_t              cfg_addr,
    input  logic [31:0]                         cfg_wdata,
    output logic [31:0]                         cfg_rdata,
    input  logic                                redirect,
    input  logic [rv32i_types::xlen-1:0]        redirect_pc,
    output logic                                imem_read,
    output logic [rv32i_types::xlen-1:0]        imem_addr,
    input  logic [rv32i_types::xlen-1:0]        imem_rdata,
    output rv32i_types::fetch_pkt_t             rdata,      // head packet, show-ahead
    input  logic                                deq,
    output logic                                full,
    output logic                                empty,
    output logic [$clog2(queue_depth):0]        count
);

    logic                         run_en;
    logic                         restart;
    logic [rv32i_types::xlen-1:0] boot_pc;
    logic                         pkt_fetched;
    logic                         enq;
    rv32i_types::fetch_pkt_t      enq_data;

    fetch_ctrl_regs u_regs (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .pkt_fetched(pkt_fetched),
        .run_en(run_en), .boot_pc(boot_pc), .restart(restart)
    );

    fetch_unit #(.queue_depth(queue_depth)) u_fetch (
        .clk(clk), .rst(rst), .run_en(run_en), .restart(restart), .boot_pc(boot_pc),
        .redirect(redirect), .redirect_pc(redirect_pc), .queue_count(count),
        .imem_read(imem_read), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .enq(enq), .enq_data(enq_data), .pkt_fetched(pkt_fetched)
    );

    // redirect doubles as the queue flush
    queue #(.queue_depth(queue_depth)) u_queue (
        .clk(clk), .rst(rst), .flush(redirect), .wdata_in(enq_data), .enqueue_in(enq),
        .rdata_out(rdata), .dequeue_in(deq), .full_out(full), .empty_out(empty),
        .count_out(count)
    );

endmodule : fetch_queue_top

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int queue_depth = 8                            // must match the queue
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    run_en,      // level from ctrl regs
    input  logic                                    restart,     // reload from boot_pc
    input  logic [rv32i_types::xlen-1:0]            boot_pc,
    input  logic                                    redirect,    // back end flush strobe
    input  logic [rv32i_types::xlen-1:0]            redirect_pc,
    input  logic [$clog2(queue_depth):0]            queue_count,
    output logic                                    imem_read,   // one cycle read strobe
    output logic [rv32i_types::xlen-1:0]            imem_addr,
    input  logic [rv32i_types::xlen-1:0]            imem_rdata,  // valid one cycle after read
    output logic                                    enq,
    output rv32i_types::fetch_pkt_t                 enq_data,
    output logic                                    pkt_fetched  // one per push
);

    localparam int cnt_w = $clog2(queue_depth) + 1;

    logic [rv32i_types::xlen-1:0] fetch_pc;                  // address of the next read
    logic [rv32i_types::xlen-1:0] inflight_pc;               // address of the read in flight
    logic                         inflight;                  // a response arrives this cycle
    logic [cnt_w-1:0]             credits_used;              // queued plus in-flight
    logic                         has_credit;
    logic                         steer;                     // redirect or restart this cycle

    assign steer = redirect || restart;

    // every in-flight read owns one queue slot until it lands
    assign credits_used = queue_count + cnt_w'(inflight);
    assign has_credit   = credits_used < cnt_w'(queue_depth);

    assign imem_read = run_en && !steer && has_credit;
    assign imem_addr = fetch_pc;

    // response pairs with its address and is dropped on a redirect or restart
    assign enq            = inflight && !steer;
    assign enq_data.pc    = inflight_pc;
    assign enq_data.instr = imem_rdata;
    assign pkt_fetched    = enq;

    // pc sequencing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fetch_pc <= '0;
        end
        else if (redirect)
        begin
            fetch_pc <= redirect_pc;                         // back end wins over restart
        end
        else if (restart)
        begin
            fetch_pc <= boot_pc;
        end
        else if (imem_read)
        begin
            fetch_pc <= fetch_pc + rv32i_types::xlen'(rv32i_types::pc_step);
        end
    end

    // fixed one cycle latency needs only a single in-flight slot
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            inflight <= 1'b0;
        end
        else
        begin
            inflight <= imem_read;                           // imem_read is already low on steer
        end
    end

    // address of the read in flight
    always_ff @(posedge clk)
    begin
        if (imem_read)
        begin
            inflight_pc <= fetch_pc;
        end
    end

    // queued plus in-flight packets stay within the queue depth
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits_used <= cnt_w'(queue_depth)
    ) else $error("fetch_unit: credits above queue depth");

endmodule : fetch_unit

// File: design/queue.sv
`timescale 1ns/1ps

module queue #(
    parameter int queue_depth = 8                       // power of two of at least 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,       // drop all entries
    input  rv32i_types::fetch_pkt_t             wdata_in,
    input  logic                                enqueue_in,
    output rv32i_types::fetch_pkt_t             rdata_out,   // head entry, show-ahead
    input  logic                                dequeue_in,
    output logic                                full_out,
    output logic                                empty_out,
    output logic [$clog2(queue_depth):0]        count_out
);

    localparam int ptr_w = $clog2(queue_depth);

    rv32i_types::fetch_pkt_t mem [queue_depth];         // packet storage

    logic [ptr_w:0] head_reg;                           // msb is the wrap bit
    logic [ptr_w:0] tail_reg;                           // msb is the wrap bit
    logic           do_enq;
    logic           do_deq;

    // same index with the wrap bits telling full from empty
    assign full_out  = (tail_reg[ptr_w-1:0] == head_reg[ptr_w-1:0]) &&
                       (tail_reg[ptr_w] != head_reg[ptr_w]);
    assign empty_out = (tail_reg[ptr_w-1:0] == head_reg[ptr_w-1:0]) &&
                       (tail_reg[ptr_w] == head_reg[ptr_w]);

    assign count_out = tail_reg - head_reg;             // wrap bit makes this exact

    assign rdata_out = mem[head_reg[ptr_w-1:0]];        // combinational head read

    assign do_enq = enqueue_in && !flush;               // flush beats a push
    assign do_deq = dequeue_in && !empty_out && !flush; // pop on empty is ignored

    // payload write, indexed by tail without the wrap bit
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            mem[tail_reg[ptr_w-1:0]] <= wdata_in;
        end
    end

    // push and pop may move both pointers in one cycle
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            head_reg <= '0;
            tail_reg <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                tail_reg <= tail_reg + 1'b1;            // carries into wrap bit on rollover
            end
            if (do_deq)
            begin
                head_reg <= head_reg + 1'b1;
            end
        end
    end

    // the producer's credits keep pushes out of a full queue
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        enqueue_in |-> !full_out
    ) else $error("queue: push while full");

    // occupancy bound holds across any mix of push, pop and flush
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count_out <= ($clog2(queue_depth)+1)'(queue_depth)
    ) else $error("queue: count above depth");

endmodule : queue

// File: design/rv32i_types.sv
package rv32i_types;

    // base integer ISA width, shared by pc and instruction words
    localparam int xlen = 32;

    // one fetched instruction with the pc it came from
    typedef struct packed {
        logic [xlen-1:0] pc;      // address of the instruction
        logic [xlen-1:0] instr;   // raw instruction word from imem
    } fetch_pkt_t;

    // control register address
    typedef logic [1:0] cfg_addr_t;

    // register map
    localparam cfg_addr_t cfg_boot_pc = 2'd0;   // boot pc, rw
    localparam cfg_addr_t cfg_enable  = 2'd1;   // run enable in bit 0, rw
    localparam cfg_addr_t cfg_fetched = 2'd2;   // fetched packet count, ro, write clears

    // pc step for uncompressed instructions
    localparam int pc_step = 4;

endpackage

// File: filelist.f
+incdir+testbench
design/rv32i_types.sv
design/queue.sv
design/fetch_unit.sv
design/fetch_ctrl_regs.sv
design/fetch_queue_top.sv
testbench/tb_fetch_queue.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch queue testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_fetch_queue -o tb_fetch_queue

out=$(./obj_dir/tb_fetch_queue)
echo "$out"

# nonzero status unless the run reported success
echo "$out" | grep -qx "Finished with no errors"

// File: testbench/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

rv32i_types::fetch_pkt_t model_q[$];          // reference queue with the head at index 0
int                      push_cnt;            // packets the model expects pushed
int                      pop_cnt;             // packets popped and compared
int                      fetch_cnt_m;         // mirror of the fetched counter register
logic [31:0]             last_pop_pc;         // pc of the most recent pop
int                      err_cnt;
int                      chk_cnt;

// instruction memory content where every address bit feeds the word
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;                 // spread low bits upward
    h = h ^ (h >> 15) ^ {addr[15:0], addr[31:16]};
    return h ^ 32'h0000_0013;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
        err_cnt++;
        $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    end
endtask

// packet the fetch unit must push for a read at pc
task automatic model_push(input logic [31:0] pc);
    rv32i_types::fetch_pkt_t p;
    p.pc    = pc;
    p.instr = mem_word(pc);
    model_q.push_back(p);
    push_cnt++;
endtask

// compare the show-ahead head with the model, then drop it
task automatic model_pop(input rv32i_types::fetch_pkt_t got);
    rv32i_types::fetch_pkt_t exp;
    exp = model_q.pop_front();
    check_value("rdata", 64'(got), 64'(exp));
    last_pop_pc = got.pc;                     // pc as seen on the dut's rdata
    pop_cnt++;
endtask

`endif

// File: testbench/tb_fetch_queue.sv
`timescale 1ns/1ps

module tb_fetch_queue;

    localparam int depth       = 8;
    localparam int cnt_w       = $clog2(depth) + 1;
    localparam int rst_cycles  = 10;
    localparam int t1_len      = 100;             // boot plus twenty pops
    localparam int t2_len      = 150;             // fill, hold, drain
    localparam int t3_len      = 300;             // random pop cycles
    localparam int t4_rounds   = 4;
    localparam int t4_len      = 60;              // per redirect round
    localparam int t5_len      = 120;
    localparam int cycle_limit = rst_cycles + t1_len + t2_len + t3_len
                                 + t4_rounds * t4_len + t5_len + 200;

    logic                         clk;
    logic                         rst;
    logic                         cfg_we;
    rv32i_types::cfg_addr_t       cfg_addr;
    logic [31:0]                  cfg_wdata;
    logic [31:0]                  cfg_rdata;
    logic                         redirect;
    logic [31:0]                  redirect_pc;
    logic                         imem_read;
    logic [31:0]                  imem_addr;
    logic [31:0]                  imem_rdata;
    rv32i_types::fetch_pkt_t      rdata;
    logic                         deq;
    logic                         full;
    logic                         empty;
    logic [cnt_w-1:0]             count;

    int                           seed;
    int                           cycle_cnt;
    logic                         inflight_m;     // read strobed in the current cycle
    logic [31:0]                  inflight_addr;
    logic [31:0]                  exp_addr;       // next address the fetch unit must issue
    logic                         run_en_m;
    logic                         restart_m;
    logic [31:0]                  boot_m;
    logic                         steer;

    `include "fetch_model.svh"

    fetch_queue_top #(.queue_depth(depth)) uut (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata), .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_read(imem_read), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .rdata(rdata), .deq(deq), .full(full), .empty(empty), .count(count)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                   // 20 ns period
    end

    // fixed one cycle memory latency
    always @(posedge clk)
    begin
        imem_rdata <= inflight_m ? mem_word(inflight_addr) : 32'h0;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout after %0d cycles, a test stalled", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    // model update at mid cycle where all dut outputs are settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            model_q.delete();
            inflight_m  = 1'b0;
            exp_addr    = 32'h0;
            run_en_m    = 1'b0;
            restart_m   = 1'b0;
            boot_m      = 32'h0;
            fetch_cnt_m = 0;
        end
        else
        begin
            steer = redirect || restart_m;        // response in flight is dropped
            check_value("empty", 64'(empty), 64'(model_q.size() == 0));
            check_value("full", 64'(full), 64'(model_q.size() == depth));
            check_value("count", 64'(count), 64'(model_q.size()));
            if (imem_read)
            begin
                check_value("imem_addr", 64'(imem_addr), 64'(exp_addr));
                if (!run_en_m || steer || (model_q.size() + int'(inflight_m) >= depth))
                    check_value("imem_read", 64'(imem_read), 64'(0));   // no credit or halted
            end
            if (redirect)
                model_q.delete();                 // flush wins over push and pop
            else
            begin
                if (deq && model_q.size() > 0)
                    model_pop(rdata);
                if (inflight_m && !restart_m)
                    model_push(inflight_addr);
            end
            if (cfg_we && cfg_addr == rv32i_types::cfg_fetched)
                fetch_cnt_m = 0;                  // clear beats a same cycle push
            else if (inflight_m && !steer)
                fetch_cnt_m++;
            if (redirect)
                exp_addr = redirect_pc;
            else if (restart_m)
                exp_addr = boot_m;
            else if (imem_read)
                exp_addr = exp_addr + 32'd4;
            inflight_m    = imem_read;
            inflight_addr = imem_addr;
            restart_m     = cfg_we && (cfg_addr == rv32i_types::cfg_boot_pc);
            if (restart_m)
                boot_m = cfg_wdata;
            if (cfg_we && cfg_addr == rv32i_types::cfg_enable)
                run_en_m = cfg_wdata[0];
        end
    end

    task automatic cfg_write(input rv32i_types::cfg_addr_t a, input logic [31:0] d);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_we    <= 1'b0;
    endtask

    task automatic cfg_read(input rv32i_types::cfg_addr_t a, output logic [31:0] d);
        @(posedge clk);
        cfg_addr <= a;
        @(negedge clk);
        d = cfg_rdata;                            // readback is combinational
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-14s %s, %0d errors", name,
                 (err_cnt == errs_before) ? "done" : "failed", err_cnt - errs_before);
    endtask

    task automatic boot_fetch();
        logic [31:0] bpc;
        int          start;
        bpc = $random(seed) & 32'hffff_fffc;
        cfg_write(rv32i_types::cfg_boot_pc, bpc);
        cfg_write(rv32i_types::cfg_enable, 32'h1);
        start = pop_cnt;
        @(posedge clk);
        deq <= 1'b1;
        while (pop_cnt == start)
            @(posedge clk);
        check_value("first_pc", 64'(last_pop_pc), 64'(bpc));
        while (pop_cnt < start + 20)              // order itself is checked per pop
            @(posedge clk);
        deq <= 1'b0;
    endtask

    task automatic back_pressure();
        int start;
        while (!full)
            @(negedge clk);
        repeat (10)
        begin
            @(negedge clk);
            check_value("imem_read", 64'(imem_read), 64'(0));   // reads held off while full
            check_value("count", 64'(count), 64'(depth));
        end
        start = pop_cnt;
        @(posedge clk);
        deq <= 1'b1;
        while (pop_cnt < start + depth)           // drain, model compares each entry
            @(posedge clk);
        deq <= 1'b0;
    endtask

    task automatic random_pop();
        repeat (t3_len)
        begin
            @(posedge clk);
            deq <= ($random(seed) & 1) == 1;      // pops on empty happen too
        end
        @(posedge clk);
        deq <= 1'b0;
    endtask

    task automatic redirect_flush();
        logic [31:0] rpc;
        int          delay;
        int          start;
        repeat (t4_rounds)
        begin
            delay = ($random(seed) & 15) + 1;
            repeat (delay)
            begin
                @(posedge clk);
                deq <= ($random(seed) & 1) == 1;
            end
            rpc = $random(seed) & 32'hffff_fffc;
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= rpc;
            @(posedge clk);
            redirect <= 1'b0;
            deq      <= 1'b1;
            start = pop_cnt;
            @(negedge clk);
            check_value("empty", 64'(empty), 64'(1));   // flushed right at the redirect edge
            while (pop_cnt == start)
                @(posedge clk);
            check_value("redirect_pc", 64'(last_pop_pc), 64'(rpc));
        end
        deq <= 1'b0;
    endtask

    task automatic enable_regs();
        logic [31:0] rd;
        logic [31:0] bpc;
        int          p0;
        cfg_write(rv32i_types::cfg_enable, 32'h0);
        repeat (3)
            @(posedge clk);                       // last read in flight lands
        p0 = push_cnt;
        deq <= 1'b1;
        repeat (20)
            @(posedge clk);
        deq <= 1'b0;
        check_value("push_cnt", 64'(push_cnt), 64'(p0));
        bpc = $random(seed) & 32'hffff_fffc;
        cfg_write(rv32i_types::cfg_boot_pc, bpc);
        cfg_read(rv32i_types::cfg_boot_pc, rd);
        check_value("cfg_boot_pc", 64'(rd), 64'(bpc));
        cfg_read(rv32i_types::cfg_enable, rd);
        check_value("cfg_enable", 64'(rd), 64'(0));
        cfg_read(rv32i_types::cfg_fetched, rd);
        check_value("cfg_fetched", 64'(rd), 64'(fetch_cnt_m));
        cfg_write(rv32i_types::cfg_fetched, 32'h0);
        cfg_read(rv32i_types::cfg_fetched, rd);
        check_value("cfg_fetched", 64'(rd), 64'(0));
    endtask

    initial
    begin
        int e;
        seed        = 98674;
        cycle_cnt   = 0;
        rst         = 1'b1;
        cfg_we      = 1'b0;
        cfg_addr    = rv32i_types::cfg_boot_pc;
        cfg_wdata   = 32'h0;
        redirect    = 1'b0;
        redirect_pc = 32'h0;
        imem_rdata  = 32'h0;
        deq         = 1'b0;
        repeat (rst_cycles)
            @(posedge clk);
        rst <= 1'b0;
        e = err_cnt;
        boot_fetch();
        report_test("boot_fetch", e);
        e = err_cnt;
        back_pressure();
        report_test("back_pressure", e);
        e = err_cnt;
        random_pop();
        report_test("random_pop", e);
        e = err_cnt;
        redirect_flush();
        report_test("redirect", e);
        e = err_cnt;
        enable_regs();
        report_test("enable_regs", e);
        $display("summary: 5 tests, %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule : tb_fetch_queue
